// ==== testbench/pwmChannelTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests of one PWM channel with gates sampled on the falling edge
// Dead time is only changed while the channel is off
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "pwm_defines.svh"

module pwmChannelTb;

    localparam int clockPeriod    = 10;
    localparam int dutyConfigs    = 4;
    // The watchdog fires after the sum of these rough per-test cycle budgets
    localparam int turnOnCycles   = 4 * 80;
    localparam int latchCycles    = 2 * 80;
    localparam int disableCycles  = 300;
    localparam int dutyCycles     = dutyConfigs * 600;
    localparam int reconfigCycles = 500;
    localparam int marginCycles   = 1000;
    localparam int totalCycles    = 4 + turnOnCycles + latchCycles + disableCycles
                                    + dutyCycles + reconfigCycles + marginCycles;

    logic                         clock;
    logic                         reset;
    logic                         enable;
    pwmConfigPkg::channelConfig_t channelConfig;
    gateDrivePkg::gatePair_t      gates;
    gateDrivePkg::gatePair_t      curGates;
    gateDrivePkg::gatePair_t      prevGates;
    gateDrivePkg::gatePair_t      lastSide;
    int                           offCount;
    int                           errorCount;
    int                           testCount;
    int                           failedTests;
    logic [31:0]                  lfsrState;

    pwmChannel DUT (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .channelConfig (channelConfig),
        .gates         (gates)
    );

    always #(clockPeriod / 2) clock = !clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step for every bit taken
    task automatic drawBits(input int width, output int value);
        int i;
        value = 0;
        for (i = 0; i < width; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = (value << 1) | lfsrState[0];
        end
    endtask

    // Draws period 8 to 63 with duty below period and dead time below 4
    // Both gates always get some on time
    task automatic drawConfig(output int period, output int duty, output int deadTime);
        logic ok;
        ok = 1'b0;
        while (!ok) begin
            period = 0;
            while (period < 8) drawBits(6, period);
            drawBits(6, duty);
            while (duty >= period) drawBits(6, duty);
            drawBits(2, deadTime);
            ok = (duty > deadTime) && (period - duty > deadTime);
        end
    endtask

    task automatic applyConfig(input int period, input int duty, input int deadTime,
                               input int delay);
        @(posedge clock);
        #1;
        channelConfig.period      = `PWM_WIDTH'(period);
        channelConfig.duty        = `PWM_WIDTH'(duty);
        channelConfig.deadTime    = `PWM_WIDTH'(deadTime);
        channelConfig.enableDelay = `COUNTER_WIDTH'(delay);
        // Two edges with enable low so the delay gets latched
        repeat (2) @(posedge clock);
    endtask

    task automatic setEnable(input logic value);
        @(posedge clock);
        #1;
        enable = value;
    endtask

    task automatic turnOff();
        setEnable(1'b0);
        repeat (6) @(posedge clock);
    endtask

    task automatic sampleGates();
        @(negedge clock);
        prevGates = curGates;
        curGates  = gates;
    endtask

    task automatic waitHighRise();
        int cycles;
        cycles = 0;
        sampleGates();
        while (!(curGates.highSide && !prevGates.highSide) && cycles < 200) begin
            sampleGates();
            cycles++;
        end
        assert (cycles < 200) else begin
            $display("highSide never rose within 200 cycles at %0t", $time);
            errorCount++;
        end
    endtask

    // Raises enable and counts edges until a gate is high
    // The expected edge follows the delay rules
    task automatic checkTurnOn(input int delay, input int deadTime, input int changeAt,
                               input int newDelay);
        int   expected;
        int   edges;
        logic seen;
        // A zero delay only keeps one register stage while a non-zero one adds start and load
        expected = (delay == 0) ? deadTime + 2 : delay + deadTime + 4;
        // Edge 0 is the first edge that samples enable high
        edges    = -1;
        seen     = 1'b0;
        setEnable(1'b1);
        while (!seen && edges < expected + 20) begin
            @(posedge clock);
            edges++;
            if (edges == changeAt) begin
                #1;
                channelConfig.enableDelay = `COUNTER_WIDTH'(newDelay);
            end
            @(negedge clock);
            seen = (gates != 2'b00);
        end
        assert (seen) else begin
            $display("No gate went high within %0d edges of enable", expected + 20);
            errorCount++;
        end
        assert (edges == expected) else begin
            $display("Mismatch first gate edge: got 0x%h expected 0x%h", edges, expected);
            errorCount++;
        end
    endtask

    // Counts cycles with each gate high from one highSide rise up to the next
    task automatic measureWindow(input int changeAt, input pwmConfigPkg::channelConfig_t newCfg,
                                 output int len, output int hsCount, output int lsCount);
        int   idx;
        logic done;
        len     = 1;
        hsCount = 1;
        lsCount = 0;
        idx     = 0;
        done    = 1'b0;
        while (!done && len < 200) begin
            idx++;
            if (idx == changeAt) begin
                @(posedge clock);
                #1;
                channelConfig = newCfg;
            end
            sampleGates();
            if (curGates.highSide && !prevGates.highSide) begin
                done = 1'b1;
            end else begin
                len++;
                hsCount += curGates.highSide;
                lsCount += curGates.lowSide;
            end
        end
        assert (done) else begin
            $display("No next highSide rise within 200 cycles at %0t", $time);
            errorCount++;
        end
    endtask

    // Each gate loses deadTime cycles of its raw PWM share
    task automatic checkWindow(input int period, input int duty, input int deadTime,
                               input int len, input int hsCount, input int lsCount);
        assert (len == period) else begin
            $display("Mismatch period: got 0x%h expected 0x%h", len, period);
            errorCount++;
        end
        assert (hsCount == duty - deadTime) else begin
            $display("Mismatch highSide time: got 0x%h expected 0x%h", hsCount, duty - deadTime);
            errorCount++;
        end
        assert (lsCount == period - duty - deadTime) else begin
            $display("Mismatch lowSide time: got 0x%h expected 0x%h",
                     lsCount, period - duty - deadTime);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: pass", name);
        end else begin
            failedTests++;
            $display("%s: fail with %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic testTurnOnDelay();
        int startErrors;
        startErrors = errorCount;
        // Zero duty keeps the raw PWM low and full duty keeps it high
        applyConfig(10, 0, 0, 0);
        checkTurnOn(0, 0, -1, 0);
        turnOff();
        applyConfig(10, 0, 2, 0);
        checkTurnOn(0, 2, -1, 0);
        turnOff();
        applyConfig(10, 0, 3, 7);
        checkTurnOn(7, 3, -1, 0);
        turnOff();
        applyConfig(10, 10, 1, 2);
        checkTurnOn(2, 1, -1, 0);
        turnOff();
        reportTest("turnOnDelay", startErrors);
    endtask

    task automatic testDelayLatching();
        int startErrors;
        startErrors = errorCount;
        applyConfig(10, 0, 1, 5);
        // New delay arrives while enable is high and must wait for the next turn-on
        checkTurnOn(5, 1, 3, 12);
        turnOff();
        checkTurnOn(12, 1, -1, 0);
        turnOff();
        reportTest("delayLatching", startErrors);
    endtask

    task automatic testDisable();
        int startErrors;
        int edges;
        startErrors = errorCount;
        applyConfig(12, 6, 1, 3);
        setEnable(1'b1);
        waitHighRise();
        repeat (3) @(posedge clock);
        setEnable(1'b0);
        // Enable is seen low on edge 1 and delayedEnable drops on edge 2 so gates are off from 3
        for (edges = 1; edges <= 40; edges++) begin
            @(posedge clock);
            @(negedge clock);
            if (edges >= 3) begin
                assert (gates == 2'b00) else begin
                    $display("Mismatch gates: got 0x%h expected 0x0", gates);
                    errorCount++;
                end
            end
        end
        reportTest("disable", startErrors);
    endtask

    task automatic testDutyDeadTime();
        int startErrors;
        int n;
        int period;
        int duty;
        int deadTime;
        int len;
        int hsCount;
        int lsCount;
        startErrors = errorCount;
        for (n = 0; n < dutyConfigs; n++) begin
            drawConfig(period, duty, deadTime);
            applyConfig(period, duty, deadTime, 0);
            setEnable(1'b1);
            // Let the shadows pick up the new carrier and the first pulse pass
            repeat (2 * period + 20) sampleGates();
            waitHighRise();
            repeat (2) begin
                measureWindow(-1, channelConfig, len, hsCount, lsCount);
                checkWindow(period, duty, deadTime, len, hsCount, lsCount);
            end
            turnOff();
        end
        reportTest("dutyDeadTime", startErrors);
    endtask

    task automatic testShadowReconfig();
        int                           startErrors;
        int                           len;
        int                           hsCount;
        int                           lsCount;
        pwmConfigPkg::channelConfig_t newCfg;
        startErrors = errorCount;
        applyConfig(20, 8, 2, 0);
        setEnable(1'b1);
        repeat (60) sampleGates();
        waitHighRise();
        newCfg        = channelConfig;
        newCfg.period = `PWM_WIDTH'(30);
        newCfg.duty   = `PWM_WIDTH'(15);
        // The change lands two cycles into the period so the old counts finish this period
        measureWindow(2, newCfg, len, hsCount, lsCount);
        checkWindow(20, 8, 2, len, hsCount, lsCount);
        measureWindow(-1, newCfg, len, hsCount, lsCount);
        checkWindow(30, 15, 2, len, hsCount, lsCount);
        turnOff();
        reportTest("shadowReconfig", startErrors);
    endtask

    // This monitor checks shoot-through and dead time for the whole run
    always @(negedge clock) begin
        if (reset) begin
            assert (!(gates.highSide && gates.lowSide)) else begin
                $display("Both gates are high at %0t", $time);
                errorCount++;
            end
            if (gates == 2'b00) begin
                offCount++;
            end else begin
                if (lastSide != 2'b00 && gates != lastSide) begin
                    assert (offCount >= channelConfig.deadTime) else begin
                        $display("Dead time too short at %0t, %0d cycles off instead of %0d",
                                 $time, offCount, channelConfig.deadTime);
                        errorCount++;
                    end
                end
                lastSide = gates;
                offCount = 0;
            end
        end
    end

    initial begin
        #(totalCycles * clockPeriod);
        $display("Watchdog expired after %0d cycles, the run did not finish", totalCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clock         = 1'b0;
        reset         = 1'b0;
        enable        = 1'b0;
        channelConfig = '0;
        channelConfig.period = `PWM_WIDTH'(10);
        curGates      = '0;
        prevGates     = '0;
        lastSide      = '0;
        offCount      = 0;
        errorCount    = 0;
        testCount     = 0;
        failedTests   = 0;
        lfsrState     = 32'hf099_e680;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;
        testTurnOnDelay();
        testDelayLatching();
        testDisable();
        testDutyDeadTime();
        testShadowReconfig();
        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/counterEnableDelay.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rising edge of enable delayed by D+3 edges (1 for D=0)
// Delay is only latched while enable is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "pwm_defines.svh"

module counterEnableDelay (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      enable,
    input  logic [`COUNTER_WIDTH-1:0] delay,
    output logic                      delayedEnable
);

    logic [`COUNTER_WIDTH-1:0] latchedDelay;
    logic [`COUNTER_WIDTH-1:0] count;
    logic                      delayIsZero;
    logic                      enableSampled;
    logic                      startPulse;
    logic                      counterLoaded;
    logic                      countInProgress;
    logic                      internalEnable;

    // A zero delay skips the counter and only keeps the register latency
    assign delayIsZero = (latchedDelay == '0);

    // The counter is loaded by the start pulse and runs while a count is in progress
    timebaseShifterCore delayCounter (
        .clock    (clock),
        .reset    (reset),
        .enable   (countInProgress),
        .load     (startPulse),
        .countIn  (latchedDelay),
        .countOut (count)
    );

    // Track the delay value only while the channel is off
    always_ff @(posedge clock) begin
        if (!reset) begin
            latchedDelay <= '0;
        end else if (!enable) begin
            latchedDelay <= delay;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            startPulse      <= 1'b0;
            counterLoaded   <= 1'b0;
            countInProgress <= 1'b0;
            internalEnable  <= 1'b0;
        end else if (!enable) begin
            // Dropping enable abandons any turn-on in progress
            startPulse      <= 1'b0;
            counterLoaded   <= 1'b0;
            countInProgress <= 1'b0;
            internalEnable  <= 1'b0;
        end else begin
            // Single pulse on the first edge that sees enable high
            startPulse    <= !enableSampled && !delayIsZero;
            // The counter holds the loaded value one cycle before counting starts
            counterLoaded <= startPulse;
            if (counterLoaded) begin
                countInProgress <= 1'b1;
            end else if (countInProgress && count == `COUNTER_WIDTH'(1)) begin
                // Count 1 is the last step, the counter parks at zero after this
                countInProgress <= 1'b0;
                internalEnable  <= 1'b1;
            end
        end
    end

    // Output stage, enableSampled also makes the falling edge one edge late
    always_ff @(posedge clock) begin
        if (!reset) begin
            enableSampled <= 1'b0;
            delayedEnable <= 1'b0;
        end else begin
            enableSampled <= enable;
            delayedEnable <= enableSampled && (delayIsZero || internalEnable);
        end
    end

endmodule

// ==== verilog/deadTimeGate.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gates rise deadTime+1 edges after delayedEnable rises
// Dead time changes apply at period start or while off
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "pwm_defines.svh"

module deadTimeGate (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    delayedEnable,
    input  gateDrivePkg::carrier_t  carrier,
    input  logic [`PWM_WIDTH-1:0]   deadTime,
    output gateDrivePkg::gatePair_t gates
);

    logic                  enabledLast;
    logic                  target;
    logic                  sideChange;
    logic [`PWM_WIDTH-1:0] deadCount;
    logic [`PWM_WIDTH-1:0] nextCount;
    logic [`PWM_WIDTH-1:0] deadTimeShadow;
    logic [`PWM_WIDTH-1:0] activeDeadTime;

    // On a period start the fresh input is used so one period never mixes two values
    assign activeDeadTime = carrier.periodStart ? deadTime : deadTimeShadow;

    // Turning on counts as a change away from the parked low side
    assign sideChange = !enabledLast || (carrier.rawPwm != target);

    // Remaining off cycles after this edge, zero means drive the target
    always_comb begin
        if (sideChange) begin
            nextCount = activeDeadTime;
        end else if (deadCount != '0) begin
            nextCount = deadCount - 1'b1;
        end else begin
            nextCount = '0;
        end
    end

    // Dead time is tracked freely while the channel is off
    always_ff @(posedge clock) begin
        if (!delayedEnable || carrier.periodStart) begin
            deadTimeShadow <= deadTime;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            enabledLast <= 1'b0;
            target      <= 1'b0;
            deadCount   <= '0;
            gates       <= '0;
        end else if (!delayedEnable) begin
            // Off state, both switches open and the target parked on the low side
            enabledLast <= 1'b0;
            target      <= 1'b0;
            deadCount   <= '0;
            gates       <= '0;
        end else begin
            enabledLast <= 1'b1;
            target      <= carrier.rawPwm;
            deadCount   <= nextCount;
            if (nextCount == '0) begin
                // Exactly one side at a time, the two are complements
                gates.highSide <= carrier.rawPwm;
                gates.lowSide  <= !carrier.rawPwm;
            end else begin
                gates <= '0;
            end
        end
    end

endmodule

// ==== verilog/gateDrivePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Carrier status and gate pair types, all active high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package gateDrivePkg;

    // Modulator output as seen by the gate stage
    typedef struct packed {
        // Requested side, 1 asks for the high side
        logic rawPwm;
        // One cycle pulse on the first cycle of each period
        logic periodStart;
    } carrier_t;

    // Complementary half-bridge gate drives
    typedef struct packed {
        logic highSide;
        logic lowSide;
    } gatePair_t;

endpackage

// ==== verilog/pwmChannel.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One half-bridge PWM channel with delayed turn-on
// First gate rises D+deadTime+4 edges after enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pwmChannel (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable,
    // Period, duty, dead time and turn-on delay in one word
    input  pwmConfigPkg::channelConfig_t channelConfig,
    output gateDrivePkg::gatePair_t     gates
);

    logic                   delayedEnable;
    gateDrivePkg::carrier_t carrier;

    // Turn-on delay from the enable level
    counterEnableDelay enableDelay (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .delay         (channelConfig.enableDelay),
        .delayedEnable (delayedEnable)
    );

    // Free-running carrier that ignores enable
    pwmModulator modulator (
        .clock   (clock),
        .reset   (reset),
        .period  (channelConfig.period),
        .duty    (channelConfig.duty),
        .carrier (carrier)
    );

    // Complementary gates with dead time that stay off until the delayed enable rises
    deadTimeGate gateStage (
        .clock         (clock),
        .reset         (reset),
        .delayedEnable (delayedEnable),
        .carrier       (carrier),
        .deadTime      (channelConfig.deadTime),
        .gates         (gates)
    );

endmodule

// ==== verilog/pwmConfigPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel configuration word, all counts in clock cycles
// Period below 2 is not supported by the modulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pwm_defines.svh"

package pwmConfigPkg;

    // One channel configuration, period in the top word
    typedef struct packed {
        // Carrier length, the counter runs 0 to period-1
        logic [`PWM_WIDTH-1:0]     period;

        // Cycles per period with the raw PWM high
        logic [`PWM_WIDTH-1:0]     duty;

        // Cycles with both gates off after every side change
        logic [`PWM_WIDTH-1:0]     deadTime;

        // Turn-on delay, only taken while enable is low
        logic [`COUNTER_WIDTH-1:0] enableDelay;
    } channelConfig_t;

endpackage

// ==== verilog/pwmModulator.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Edge-aligned carrier, new period and duty take effect at wrap
// Period must be at least 2, duty at or above period gives 100%
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "pwm_defines.svh"

module pwmModulator (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`PWM_WIDTH-1:0]  period,
    input  logic [`PWM_WIDTH-1:0]  duty,
    output gateDrivePkg::carrier_t carrier
);

    logic [`PWM_WIDTH-1:0] count;
    logic [`PWM_WIDTH-1:0] nextCount;
    logic [`PWM_WIDTH-1:0] shadowPeriod;
    logic [`PWM_WIDTH-1:0] shadowDuty;
    logic [`PWM_WIDTH-1:0] nextDuty;
    logic                  wrap;

    // Greater-or-equal so a shorter period loaded elsewhere cannot run away
    assign wrap      = (count >= shadowPeriod - 1'b1);
    assign nextCount = wrap ? '0 : count + 1'b1;

    // The first cycle of a new period already compares against the new duty
    assign nextDuty = wrap ? duty : shadowDuty;

    // Shadows follow the inputs during reset and are refreshed at every wrap
    always_ff @(posedge clock) begin
        if (!reset || wrap) begin
            shadowPeriod <= period;
            shadowDuty   <= duty;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            count   <= '0;
            carrier <= '0;
        end else begin
            count <= nextCount;
            // rawPwm is aligned with count, high while count is below duty
            carrier.rawPwm      <= (nextCount < nextDuty);
            // Not raised for the very first period after reset release
            carrier.periodStart <= wrap;
        end
    end

endmodule

// ==== verilog/pwm_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counter widths shared by the packages and the RTL
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// Width of the turn-on delay counts
`define COUNTER_WIDTH 16

// Width of the carrier, duty and dead-time counts
`define PWM_WIDTH 16

`endif

// ==== verilog/timebaseShifterCore.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Down counter, load wins over count, stops at zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "pwm_defines.svh"

module timebaseShifterCore (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      enable,
    input  logic                      load,
    input  logic [`COUNTER_WIDTH-1:0] countIn,
    output logic [`COUNTER_WIDTH-1:0] countOut
);

    // The count is registered, so a load shows up one edge later
    always_ff @(posedge clock) begin
        if (!reset) begin
            countOut <= '0;
        end else if (load) begin
            // A fresh load restarts the count even mid-run
            countOut <= countIn;
        end else if (enable && countOut != '0) begin
            countOut <= countOut - 1'b1;
        end
        // Otherwise hold, zero is sticky until the next load
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/pwmConfigPkg.sv
verilog/gateDrivePkg.sv
verilog/timebaseShifterCore.sv
verilog/counterEnableDelay.sv
verilog/pwmModulator.sv
verilog/deadTimeGate.sv
verilog/pwmChannel.sv
testbench/pwmChannelTb.sv
